// File: include/xv_params.svh
/* video timing, memory size and interrupt bit definitions
   shared by the design and the testbench, include where needed */

`ifndef XV_PARAMS_SVH
`define XV_PARAMS_SVH

// horizontal timing in pixel clocks
`define XV_H_VISIBLE    32
`define XV_H_FRONT      4
`define XV_H_SYNC       4
`define XV_H_BACK       4
`define XV_H_TOTAL      (`XV_H_VISIBLE + `XV_H_FRONT + `XV_H_SYNC + `XV_H_BACK)

// vertical timing in lines
`define XV_V_VISIBLE    8
`define XV_V_FRONT      1
`define XV_V_SYNC       1
`define XV_V_BACK       2
`define XV_V_TOTAL      (`XV_V_VISIBLE + `XV_V_FRONT + `XV_V_SYNC + `XV_V_BACK)

`define XV_PIX_PER_WORD 4       // 4-bit pixels in a 16-bit word
`define XV_VRAM_AW      8       // 256 words of VRAM
`define XV_INTR_W       4       // interrupt vector width
`define XV_INTR_VBLANK  0       // vblank interrupt bit
`define XV_VID_LATENCY  3       // counter to output pins

`endif

// File: design/xv_pkg.sv
/* common types of the video controller
   referenced everywhere with scoped names */

`default_nettype none

`include "xv_params.svh"

package xv_pkg;

    typedef logic [15:0]              word_t;     // register / VRAM word
    typedef logic [`XV_VRAM_AW-1:0]   addr_t;     // VRAM word address
    typedef logic [3:0]               color_t;    // palette index
    typedef logic [11:0]              rgb_t;      // {r, g, b}, red high
    typedef logic [`XV_INTR_W-1:0]    intr_t;     // interrupt vector

    // CPU visible register numbers
    typedef enum logic [3:0] {
        XM_SYS_CTRL = 4'h0,     // busy, interrupt mask
        XM_INT_CTRL = 4'h1,     // signal / clear / status
        XM_WR_INCR  = 4'h2,
        XM_WR_ADDR  = 4'h3,
        XM_DATA     = 4'h4,     // VRAM data port
        XM_RD_INCR  = 4'h5,
        XM_RD_ADDR  = 4'h6,
        XM_XR_ADDR  = 4'h7,     // palette index
        XM_XR_DATA  = 4'h8      // palette write data
    } xm_reg_e;

    // register interface memory sequencer
    typedef enum logic [1:0] {
        MEM_IDLE,
        MEM_WRITE,
        MEM_READ
    } mem_state_e;

endpackage

`default_nettype wire

// File: design/xv_mem_if.sv
/* select/ack memory request from the register interface to VRAM
   requester holds sel and payload until a one-cycle ack */

`default_nettype none

interface xv_mem_if;

    logic           sel;        // request open
    logic           wr;         // 1 = write, 0 = read
    xv_pkg::addr_t  addr;       // word address
    xv_pkg::word_t  wdata;      // write word
    xv_pkg::word_t  rdata;      // read word, valid with ack
    logic           ack;        // single-cycle completion

    modport requester (
        output sel, wr, addr, wdata,
        input  rdata, ack
    );

    modport arbiter (
        input  sel, wr, addr, wdata,
        output rdata, ack
    );

endinterface

`default_nettype wire

// File: design/reg_interface.sv
/* CPU byte bus register file: address registers, VRAM data port,
   palette write port and the interrupt mask/status logic */

`default_nettype none

`include "xv_params.svh"

module reg_interface (
    input  wire logic           clk,
    input  wire logic           reset_i,
    input  wire logic           bus_cs_n_i,     // low = access this clock
    input  wire logic           bus_rd_nwr_i,   // 1 = read
    input  wire logic           bus_bytesel_i,  // 0 = even (high) byte
    input  wire logic [3:0]     bus_reg_num_i,
    input  wire logic [7:0]     bus_data_i,
    output logic      [7:0]     bus_data_o,
    output logic                bus_intr_o,
    xv_mem_if.requester         mem,
    output logic                pal_wr_o,
    output xv_pkg::color_t      pal_index_o,
    output xv_pkg::rgb_t        pal_rgb_o,
    input  wire logic           vblank_intr_i
);

    xv_pkg::xm_reg_e    reg_num;
    xv_pkg::mem_state_e mem_state;
    logic               rd_access;      // read strobe, either byte
    logic               commit;         // odd byte write, full word
    logic               data_wr, data_rd, rdaddr_wr, int_wr;
    logic               busy;
    logic [7:0]         hi_byte;        // latched even byte
    xv_pkg::word_t      wdata;          // committed word
    xv_pkg::word_t      reg_val;        // read mux
    xv_pkg::word_t      rd_next;
    xv_pkg::word_t      wr_incr, wr_addr, rd_incr, rd_addr, xr_addr;
    xv_pkg::word_t      rd_data;        // read prefetch word
    xv_pkg::addr_t      req_addr;
    xv_pkg::word_t      req_wdata;
    xv_pkg::intr_t      intr_mask, intr_status, intr_signal, intr_clear;

    assign reg_num   = xv_pkg::xm_reg_e'(bus_reg_num_i);
    assign rd_access = ~bus_cs_n_i & bus_rd_nwr_i;
    assign commit    = ~bus_cs_n_i & ~bus_rd_nwr_i & bus_bytesel_i;
    assign wdata     = {hi_byte, bus_data_i};
    assign rd_next   = rd_addr + rd_incr;

    // VRAM triggers
    assign data_wr   = commit && (reg_num == xv_pkg::XM_DATA);
    assign rdaddr_wr = commit && (reg_num == xv_pkg::XM_RD_ADDR);
    assign data_rd   = rd_access && bus_bytesel_i && (reg_num == xv_pkg::XM_DATA);
    assign int_wr    = commit && (reg_num == xv_pkg::XM_INT_CTRL);
    assign busy      = (mem_state != xv_pkg::MEM_IDLE);

    assign mem.sel   = busy;            // held until ack by the FSM
    assign mem.wr    = (mem_state == xv_pkg::MEM_WRITE);
    assign mem.addr  = req_addr;
    assign mem.wdata = req_wdata;

    // vblank plus CPU signal bits, CPU clear bits
    always_comb begin
        intr_signal = '0;
        intr_clear  = '0;
        intr_signal[`XV_INTR_VBLANK] = vblank_intr_i;
        if (int_wr) begin
            intr_signal = intr_signal | wdata[8 +: `XV_INTR_W];
            intr_clear  = wdata[`XV_INTR_W-1:0];
        end
    end

    always_comb begin
        case (reg_num)
            xv_pkg::XM_SYS_CTRL: reg_val = {busy, {(15 - `XV_INTR_W){1'b0}}, intr_mask};
            xv_pkg::XM_INT_CTRL: reg_val = {{(16 - `XV_INTR_W){1'b0}}, intr_status};
            xv_pkg::XM_WR_INCR:  reg_val = wr_incr;
            xv_pkg::XM_WR_ADDR:  reg_val = wr_addr;
            xv_pkg::XM_DATA:     reg_val = rd_data;     // prefetched word
            xv_pkg::XM_RD_INCR:  reg_val = rd_incr;
            xv_pkg::XM_RD_ADDR:  reg_val = rd_addr;
            xv_pkg::XM_XR_ADDR:  reg_val = xr_addr;
            default:             reg_val = '0;          // XR_DATA and unused
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            mem_state   <= xv_pkg::MEM_IDLE;
            wr_incr     <= '0;
            wr_addr     <= '0;
            rd_incr     <= '0;
            rd_addr     <= '0;
            xr_addr     <= '0;
            intr_mask   <= '0;
            intr_status <= '0;
            bus_intr_o  <= 1'b0;
            pal_wr_o    <= 1'b0;
        end else begin
            pal_wr_o <= 1'b0;
            if (commit) begin
                case (reg_num)
                    xv_pkg::XM_SYS_CTRL: intr_mask <= wdata[`XV_INTR_W-1:0];
                    xv_pkg::XM_WR_INCR:  wr_incr <= wdata;
                    xv_pkg::XM_WR_ADDR:  wr_addr <= wdata;
                    xv_pkg::XM_DATA:     wr_addr <= wr_addr + wr_incr;  // post increment
                    xv_pkg::XM_RD_INCR:  rd_incr <= wdata;
                    xv_pkg::XM_RD_ADDR:  rd_addr <= wdata;
                    xv_pkg::XM_XR_ADDR:  xr_addr <= wdata;
                    xv_pkg::XM_XR_DATA: begin
                        pal_wr_o <= 1'b1;
                        xr_addr  <= xr_addr + 16'd1;
                    end
                    default: ;
                endcase
            end
            if (data_rd)
                rd_addr <= rd_next;         // advance, then prefetch there
            // one request at a time, new triggers ignored while busy
            case (mem_state)
                xv_pkg::MEM_IDLE: begin
                    if (data_wr)
                        mem_state <= xv_pkg::MEM_WRITE;
                    else if (rdaddr_wr || data_rd)
                        mem_state <= xv_pkg::MEM_READ;
                end
                default: begin
                    if (mem.ack)
                        mem_state <= xv_pkg::MEM_IDLE;
                end
            endcase
            bus_intr_o  <= |(intr_signal & intr_mask & ~intr_status);   // new, enabled
            intr_status <= (intr_status | intr_signal) & ~intr_clear;
        end
    end

    // data path, no reset
    always_ff @(posedge clk) begin
        if (~bus_cs_n_i && ~bus_rd_nwr_i && ~bus_bytesel_i)
            hi_byte <= bus_data_i;
        if (rd_access)
            bus_data_o <= bus_bytesel_i ? reg_val[7:0] : reg_val[15:8];
        if (!busy) begin
            if (data_wr) begin
                req_addr  <= wr_addr[`XV_VRAM_AW-1:0];
                req_wdata <= wdata;
            end else if (rdaddr_wr) begin
                req_addr  <= wdata[`XV_VRAM_AW-1:0];
            end else if (data_rd) begin
                req_addr  <= rd_next[`XV_VRAM_AW-1:0];
            end
        end
        if (mem_state == xv_pkg::MEM_READ && mem.ack)
            rd_data <= mem.rdata;
        if (commit && reg_num == xv_pkg::XM_XR_DATA) begin
            pal_index_o <= xr_addr[3:0];
            pal_rgb_o   <= wdata[11:0];
        end
    end

    // open request keeps its address and direction until acked
    a_req_hold: assert property (@(posedge clk) disable iff (reset_i)
        mem.sel && !mem.ack |=> $stable(mem.addr) && $stable(mem.wr))
        else $error("request changed before its ack");

endmodule

`default_nettype wire

// File: design/vram_arb.sv
/* single-port VRAM shared by video fetch and register interface
   video always wins, register port waits with select/ack */

`default_nettype none

`include "xv_params.svh"

module vram_arb (
    input  wire logic           clk,
    input  wire logic           vgen_sel_i,     // video fetch this cycle
    input  wire xv_pkg::addr_t  vgen_addr_i,
    output xv_pkg::word_t       vram_data_o,    // one cycle after grant
    xv_mem_if.arbiter           regs
);

    xv_pkg::word_t  vram [2**`XV_VRAM_AW];
    xv_pkg::word_t  data_q;
    xv_pkg::addr_t  addr;           // shared port address
    logic           reg_grant;
    logic           ack_q;

    // no grant in the ack cycle, sel drops the cycle after
    assign reg_grant = regs.sel & ~vgen_sel_i & ~ack_q;
    assign addr      = vgen_sel_i ? vgen_addr_i : regs.addr;

    always_ff @(posedge clk) begin
        if (reg_grant && regs.wr)
            vram[addr] <= regs.wdata;
        data_q <= vram[addr];       // old data on write
    end

    always_ff @(posedge clk) begin
        ack_q <= reg_grant;
    end

    assign vram_data_o = data_q;
    assign regs.rdata  = data_q;
    assign regs.ack    = ack_q;

    // requester must hold sel until acked
    a_ack_sel: assert property (@(posedge clk) regs.ack |-> regs.sel)
        else $error("ack without open request");

endmodule

`default_nettype wire

// File: design/video_gen.sv
/* raster counters, VRAM pixel fetch and 4-bit pixel shifter
   syncs and display enable delayed to line up with the pixels */

`default_nettype none

`include "xv_params.svh"

module video_gen (
    input  wire logic           clk,
    input  wire logic           reset_i,
    output logic                vram_sel_o,
    output xv_pkg::addr_t       vram_addr_o,
    input  wire xv_pkg::word_t  vram_data_i,
    output xv_pkg::color_t      pix_index_o,
    output logic                pix_de_o,
    output logic                pix_hsync_o,
    output logic                pix_vsync_o,
    output logic                vblank_intr_o
);

    localparam int HW  = $clog2(`XV_H_TOTAL);
    localparam int VW  = $clog2(`XV_V_TOTAL);
    localparam int DLY = `XV_VID_LATENCY - 1;          // last stage is color_lut
    localparam int WORDS_PER_LINE = `XV_H_VISIBLE / `XV_PIX_PER_WORD;
    localparam int HS_START = `XV_H_VISIBLE + `XV_H_FRONT;
    localparam int VS_LINE  = `XV_V_VISIBLE + `XV_V_FRONT;

    logic [HW-1:0]  h_count;
    logic [VW-1:0]  v_count;
    logic           visible, hsync, vsync;
    logic           fetch_q;                // data from vram_arb this cycle
    xv_pkg::word_t  shifter;
    logic [2:0]     sync_q [DLY];           // {de, hsync, vsync}

    always_ff @(posedge clk) begin
        if (reset_i) begin
            h_count <= '0;
            v_count <= '0;
        end else if (h_count == HW'(`XV_H_TOTAL - 1)) begin
            h_count <= '0;
            if (v_count == VW'(`XV_V_TOTAL - 1))
                v_count <= '0;
            else
                v_count <= v_count + 1'b1;
        end else begin
            h_count <= h_count + 1'b1;
        end
    end

    assign visible = (h_count < HW'(`XV_H_VISIBLE)) && (v_count < VW'(`XV_V_VISIBLE));
    assign hsync   = (h_count >= HW'(HS_START)) && (h_count < HW'(HS_START + `XV_H_SYNC));
    assign vsync   = (v_count == VW'(VS_LINE));
    assign vblank_intr_o = (h_count == '0) && (v_count == VW'(`XV_V_VISIBLE));

    // one word per group, base 0, line stride WORDS_PER_LINE
    assign vram_sel_o  = visible && (h_count % `XV_PIX_PER_WORD == 0);
    assign vram_addr_o = xv_pkg::addr_t'(v_count * WORDS_PER_LINE
                                         + h_count / `XV_PIX_PER_WORD);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            fetch_q <= 1'b0;
            for (int i = 0; i < DLY; i++)
                sync_q[i] <= '0;
        end else begin
            fetch_q   <= vram_sel_o;
            sync_q[0] <= {visible, hsync, vsync};
            for (int i = 1; i < DLY; i++)
                sync_q[i] <= sync_q[i-1];
        end
    end

    // load on return, else shift next nibble up
    always_ff @(posedge clk) begin
        if (fetch_q)
            shifter <= vram_data_i;
        else
            shifter <= {shifter[11:0], 4'h0};
    end

    assign pix_index_o = shifter[15:12];        // msn first
    assign pix_de_o    = sync_q[DLY-1][2];
    assign pix_hsync_o = sync_q[DLY-1][1];
    assign pix_vsync_o = sync_q[DLY-1][0];

    // each fetch must address a word of the displayed frame
    a_fetch_vis: assert property (@(posedge clk) disable iff (reset_i)
        vram_sel_o |-> (vram_addr_o < xv_pkg::addr_t'(WORDS_PER_LINE * `XV_V_VISIBLE)))
        else $error("fetch outside visible area");

endmodule

`default_nettype wire

// File: design/color_lut.sv
/* 16 entry palette and final registered RGB/sync stage
   CPU writes entries, video reads one per clock */

`default_nettype none

module color_lut (
    input  wire logic           clk,
    input  wire logic           pal_wr_i,
    input  wire xv_pkg::color_t pal_index_i,
    input  wire xv_pkg::rgb_t   pal_rgb_i,
    input  wire xv_pkg::color_t pix_index_i,
    input  wire logic           pix_de_i,
    input  wire logic           pix_hsync_i,
    input  wire logic           pix_vsync_i,
    output xv_pkg::rgb_t        rgb_o,
    output logic                hsync_o,
    output logic                vsync_o,
    output logic                dv_de_o
);

    xv_pkg::rgb_t   palette [16];

    always_ff @(posedge clk) begin
        if (pal_wr_i)
            palette[pal_index_i] <= pal_rgb_i;
    end

    // black outside display
    always_ff @(posedge clk) begin
        rgb_o   <= pix_de_i ? palette[pix_index_i] : '0;
        hsync_o <= pix_hsync_i;
        vsync_o <= pix_vsync_i;
        dv_de_o <= pix_de_i;
    end

endmodule

`default_nettype wire

// File: design/xosera_main.sv
/* top level of the bitmap video controller
   CPU byte bus in, 12-bit RGB with syncs out */

`default_nettype none

module xosera_main (
    input  wire logic           clk,
    input  wire logic           reset_i,
    input  wire logic           bus_cs_n_i,
    input  wire logic           bus_rd_nwr_i,
    input  wire logic           bus_bytesel_i,
    input  wire logic [3:0]     bus_reg_num_i,
    input  wire logic [7:0]     bus_data_i,
    output logic      [7:0]     bus_data_o,
    output logic                bus_intr_o,
    output logic      [3:0]     red_o,
    output logic      [3:0]     green_o,
    output logic      [3:0]     blue_o,
    output logic                hsync_o,
    output logic                vsync_o,
    output logic                dv_de_o
);

    xv_mem_if           mem_bus ();     // regs to VRAM

    logic               vgen_sel;
    xv_pkg::addr_t      vgen_addr;
    xv_pkg::word_t      vram_data;
    logic               pal_wr;
    xv_pkg::color_t     pal_index;
    xv_pkg::rgb_t       pal_rgb;
    xv_pkg::color_t     pix_index;
    logic               pix_de, pix_hsync, pix_vsync;
    logic               vblank_intr;
    xv_pkg::rgb_t       rgb;

    reg_interface u_regs (
        .clk, .reset_i,
        .bus_cs_n_i, .bus_rd_nwr_i, .bus_bytesel_i, .bus_reg_num_i,
        .bus_data_i, .bus_data_o, .bus_intr_o,
        .mem(mem_bus.requester),
        .pal_wr_o(pal_wr), .pal_index_o(pal_index), .pal_rgb_o(pal_rgb),
        .vblank_intr_i(vblank_intr)
    );

    vram_arb u_vram (
        .clk,
        .vgen_sel_i(vgen_sel), .vgen_addr_i(vgen_addr),
        .vram_data_o(vram_data),
        .regs(mem_bus.arbiter)
    );

    video_gen u_vgen (
        .clk, .reset_i,
        .vram_sel_o(vgen_sel), .vram_addr_o(vgen_addr), .vram_data_i(vram_data),
        .pix_index_o(pix_index), .pix_de_o(pix_de),
        .pix_hsync_o(pix_hsync), .pix_vsync_o(pix_vsync),
        .vblank_intr_o(vblank_intr)
    );

    color_lut u_lut (
        .clk,
        .pal_wr_i(pal_wr), .pal_index_i(pal_index), .pal_rgb_i(pal_rgb),
        .pix_index_i(pix_index), .pix_de_i(pix_de),
        .pix_hsync_i(pix_hsync), .pix_vsync_i(pix_vsync),
        .rgb_o(rgb), .hsync_o, .vsync_o, .dv_de_o
    );

    assign {red_o, green_o, blue_o} = rgb;      // red in the high nibble

endmodule

`default_nettype wire

// File: test/tb_xosera.sv
/* directed testbench for the bitmap video controller
   drives the CPU byte bus on falling edges and checks VRAM access,
   raster output, sync shape and interrupts against a model of the rules */

`default_nettype none

`include "xv_params.svh"

module tb_xosera;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int FRAME_CYCLES   = `XV_H_TOTAL * `XV_V_TOTAL;
    localparam int TIMEOUT_CYCLES = 20 * FRAME_CYCLES;     // tests take about 10 frames
    localparam int WORDS_PER_LINE = `XV_H_VISIBLE / `XV_PIX_PER_WORD;

    logic           clk = 1'b0;
    logic           reset_i;
    logic           bus_cs_n_i, bus_rd_nwr_i, bus_bytesel_i;
    logic [3:0]     bus_reg_num_i;
    logic [7:0]     bus_data_i;
    logic [7:0]     bus_data_o;
    logic           bus_intr_o;
    logic [3:0]     red_o, green_o, blue_o;
    logic           hsync_o, vsync_o, dv_de_o;

    logic [15:0]    vram_model [256];       // words written by the tests
    logic [11:0]    pal_model [16];
    int             intr_pulses = 0;
    int             cycle_count = 0;

    xosera_main dut (.*);

    always #50 clk = ~clk;                  // 100 ns period

    // outputs are registered on the rising edge, stable here
    always @(negedge clk) begin
        if (bus_intr_o === 1'b1)
            intr_pulses <= intr_pulses + 1;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("=== FAIL ===");
            $fatal(1, "timeout: tests still running after %0d cycles", TIMEOUT_CYCLES);
        end
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            $display("=== FAIL ===");
            $fatal(1, "check on %s failed", name);
        end
    endtask

    task automatic idle(input int n);
        repeat (n) @(negedge clk);
    endtask

    // one byte access, called and returning on a falling edge
    task automatic bus_access(input logic rd, input logic bsel, input logic [3:0] num,
                              input logic [7:0] din, output logic [7:0] dout);
        bus_cs_n_i    = 1'b0;
        bus_rd_nwr_i  = rd;
        bus_bytesel_i = bsel;
        bus_reg_num_i = num;
        bus_data_i    = din;
        @(posedge clk);
        @(negedge clk);
        bus_cs_n_i = 1'b1;
        dout = bus_data_o;                  // read byte lands one cycle after
    endtask

    task automatic write_reg(input logic [3:0] num, input logic [15:0] val);
        logic [7:0] unused;
        bus_access(1'b0, 1'b0, num, val[15:8], unused);     // high byte latched
        bus_access(1'b0, 1'b1, num, val[7:0], unused);      // commit
    endtask

    task automatic read_reg(input logic [3:0] num, output logic [15:0] val);
        logic [7:0] hi, lo;
        bus_access(1'b1, 1'b0, num, 8'h00, hi);
        bus_access(1'b1, 1'b1, num, 8'h00, lo);
        val = {hi, lo};
    endtask

    // busy is SYS_CTRL bit 15
    task automatic wait_idle;
        logic [7:0] hi;
        bus_access(1'b1, 1'b0, xv_pkg::XM_SYS_CTRL, 8'h00, hi);
        while (hi[7])
            bus_access(1'b1, 1'b0, xv_pkg::XM_SYS_CTRL, 8'h00, hi);
    endtask

    task automatic wait_vsync_rise;
        logic prev;
        prev = vsync_o;
        @(negedge clk);
        while (!(vsync_o && !prev)) begin
            prev = vsync_o;
            @(negedge clk);
        end
    endtask

    // n-th displayed pixel in raster order, msn of each word first
    function automatic logic [11:0] pixel_color(input int n);
        int          v, h;
        logic [15:0] w;
        v = n / `XV_H_VISIBLE;
        h = n % `XV_H_VISIBLE;
        w = vram_model[v * WORDS_PER_LINE + h / `XV_PIX_PER_WORD];
        return pal_model[w[15 - 4 * (h % `XV_PIX_PER_WORD) -: 4]];
    endfunction

    task automatic fill_vram(input logic [15:0] start, input int count);
        logic [15:0] w;
        write_reg(xv_pkg::XM_WR_INCR, 16'd1);
        write_reg(xv_pkg::XM_WR_ADDR, start);
        for (int i = 0; i < count; i++) begin
            w = 16'($urandom());
            vram_model[8'(start + i)] = w;
            write_reg(xv_pkg::XM_DATA, w);
            wait_idle();                    // one VRAM request at a time
        end
    endtask

    task automatic test_reset_state;
        logic [15:0] val;
        check_value("bus_intr_o", bus_intr_o, 0);
        check_value("dv_de_o", dv_de_o, 0);
        read_reg(xv_pkg::XM_INT_CTRL, val);
        check_value("XM_INT_CTRL", val, 0);
        read_reg(xv_pkg::XM_SYS_CTRL, val);
        check_value("XM_SYS_CTRL", val, 0);
    endtask

    task automatic test_vram_round_trip;
        logic [15:0] val;
        fill_vram(16'h0040, 64);
        read_reg(xv_pkg::XM_WR_ADDR, val);
        check_value("XM_WR_ADDR", val, 16'h0080);
        write_reg(xv_pkg::XM_RD_INCR, 16'd1);
        write_reg(xv_pkg::XM_RD_ADDR, 16'h0040);   // prefetch first word
        wait_idle();
        for (int i = 0; i < 64; i++) begin
            read_reg(xv_pkg::XM_DATA, val);         // odd byte fetches the next
            check_value("XM_DATA", val, vram_model[8'h40 + i]);
            wait_idle();
        end
        read_reg(xv_pkg::XM_RD_ADDR, val);
        check_value("XM_RD_ADDR", val, 16'h0080);
    endtask

    task automatic test_display;
        logic [15:0] w;
        logic [11:0] rgb;
        logic        prev_vs;
        int          n;
        write_reg(xv_pkg::XM_XR_ADDR, 16'h0000);
        for (int i = 0; i < 16; i++) begin
            w = 16'($urandom());            // top nibble ignored
            pal_model[i] = w[11:0];
            write_reg(xv_pkg::XM_XR_DATA, w);
        end
        fill_vram(16'h0000, 64);
        wait_vsync_rise();
        n = 0;
        prev_vs = vsync_o;
        @(negedge clk);
        while (!(vsync_o && !prev_vs)) begin    // one whole frame
            rgb = {red_o, green_o, blue_o};
            if (dv_de_o) begin
                if (n < 256)
                    check_value("rgb", rgb, pixel_color(n));
                n++;
            end else begin
                check_value("rgb while blank", rgb, 0);
            end
            prev_vs = vsync_o;
            @(negedge clk);
        end
        check_value("dv_de_o cycles per frame", n, 256);
    endtask

    task automatic test_sync;
        int   hs_len, last_rise, pulses, vs_len;
        logic prev_hs;
        wait_vsync_rise();
        hs_len    = 0;
        last_rise = -1;
        pulses    = 0;
        vs_len    = 0;
        prev_hs   = hsync_o;
        for (int i = 0; i < FRAME_CYCLES; i++) begin
            if (vsync_o)
                vs_len++;
            if (hsync_o) begin
                if (!prev_hs) begin
                    if (last_rise >= 0)
                        check_value("hsync period", i - last_rise, `XV_H_TOTAL);
                    last_rise = i;
                    pulses++;
                    hs_len = 0;
                end
                hs_len++;
            end else if (prev_hs) begin
                check_value("hsync width", hs_len, `XV_H_SYNC);
            end
            prev_hs = hsync_o;
            @(negedge clk);
        end
        check_value("hsync pulses per frame", pulses, `XV_V_TOTAL);
        check_value("vsync width", vs_len, `XV_H_TOTAL * `XV_V_SYNC);
    endtask

    task automatic test_cpu_intr;
        logic [15:0] val;
        int          base;
        wait_vsync_rise();                  // vblank is lines away
        write_reg(xv_pkg::XM_SYS_CTRL, 16'h0000);
        write_reg(xv_pkg::XM_INT_CTRL, 16'h000f);
        base = intr_pulses;
        write_reg(xv_pkg::XM_INT_CTRL, 16'h0200);  // signal bit 1, masked
        idle(2);
        check_value("bus_intr_o pulses masked", intr_pulses - base, 0);
        read_reg(xv_pkg::XM_INT_CTRL, val);
        check_value("XM_INT_CTRL", val, 16'h0002);
        write_reg(xv_pkg::XM_INT_CTRL, 16'h0002);
        write_reg(xv_pkg::XM_SYS_CTRL, 16'h0002);  // enable bit 1
        write_reg(xv_pkg::XM_INT_CTRL, 16'h0200);
        idle(2);
        check_value("bus_intr_o pulses enabled", intr_pulses - base, 1);
        read_reg(xv_pkg::XM_INT_CTRL, val);
        check_value("XM_INT_CTRL", val, 16'h0002);
        write_reg(xv_pkg::XM_INT_CTRL, 16'h0002);
        read_reg(xv_pkg::XM_INT_CTRL, val);
        check_value("XM_INT_CTRL after clear", val, 16'h0000);
    endtask

    task automatic test_vblank_intr;
        logic [15:0] val;
        int          base;
        wait_vsync_rise();
        write_reg(xv_pkg::XM_INT_CTRL, 16'h000f);
        write_reg(xv_pkg::XM_SYS_CTRL, 16'h0001);
        base = intr_pulses;
        idle(FRAME_CYCLES);                 // exactly one vblank inside
        check_value("vblank bus_intr_o pulses", intr_pulses - base, 1);
        read_reg(xv_pkg::XM_INT_CTRL, val);
        check_value("XM_INT_CTRL vblank", val, 16'h0001);
        idle(20);
        read_reg(xv_pkg::XM_INT_CTRL, val);
        check_value("XM_INT_CTRL vblank held", val, 16'h0001);
        write_reg(xv_pkg::XM_INT_CTRL, 16'h0001);
        read_reg(xv_pkg::XM_INT_CTRL, val);
        check_value("XM_INT_CTRL after clear", val, 16'h0000);
    endtask

    initial begin
        void'($urandom(32'hba49fafd));
        reset_i       = 1'b1;
        bus_cs_n_i    = 1'b1;
        bus_rd_nwr_i  = 1'b1;
        bus_bytesel_i = 1'b0;
        bus_reg_num_i = 4'h0;
        bus_data_i    = 8'h00;
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset_i = 1'b0;
        test_reset_state();
        test_vram_round_trip();
        test_display();
        test_sync();
        test_cpu_intr();
        test_vblank_intr();
        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+include
design/xv_pkg.sv
design/xv_mem_if.sv
design/reg_interface.sv
design/vram_arb.sv
design/video_gen.sv
design/color_lut.sv
design/xosera_main.sv
test/tb_xosera.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0 -Mdir obj_dir
TOP       = tb_xosera
FLIST     = vlog.f

.PHONY: sim clean

# build, then run; a $fatal in the testbench gives a nonzero exit
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
